// ==== rtl/hazardPkg.sv ====
package hazardPkg;

	// register number, x0 reads as zero
	typedef logic [4:0] regAddrT;

	// bypass source for one operand
	typedef logic [1:0] fwdSelT;

	// where an instruction's result comes from in writeback
	typedef logic [1:0] wbSelT;

	localparam regAddrT RegZero = 5'd0;

	// bypass source codes
	localparam fwdSelT FwdNone    = 2'b00;
	localparam fwdSelT FwdResultW = 2'b01;
	localparam fwdSelT FwdAluM    = 2'b10;

	// writeback source codes
	localparam wbSelT WbAlu = 2'b00;
	localparam wbSelT WbMem = 2'b01;

	// instruction sitting in decode
	typedef struct packed {
		regAddrT adr1;
		regAddrT adr2;
		regAddrT rd;
		logic    regWrite;
		wbSelT   wbSel;
		logic    branch;
		logic    jump;
	} decodeInfoT;

	// record carried through E, M and W
	typedef struct packed {
		regAddrT adr1;
		regAddrT adr2;
		regAddrT rd;
		logic    regWrite;
		wbSelT   wbSel;
	} stageInfoT;

	// all four operand selects
	typedef struct packed {
		fwdSelT fwd1D;
		fwdSelT fwd2D;
		fwdSelT fwd1E;
		fwdSelT fwd2E;
	} fwdSelsT;

	// empty slot, writes nothing
	localparam stageInfoT StageBubble = '{
		adr1:     RegZero,
		adr2:     RegZero,
		rd:       RegZero,
		regWrite: 1'b0,
		wbSel:    WbAlu
	};

endpackage

// ==== rtl/pipeTracker.sv ====
`timescale 1ns/100ps

module pipeTracker
	import hazardPkg::*;
#(
	parameter int DataWidth = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  decodeInfoT           decodeIn,
	input  logic                 flushE,
	input  logic [DataWidth-1:0] aluResultE,
	input  logic [DataWidth-1:0] memDataW,
	output stageInfoT            infoE,
	output stageInfoT            infoM,
	output stageInfoT            infoW,
	output logic [DataWidth-1:0] aluM,
	output logic [DataWidth-1:0] resultW
);

	typedef logic [DataWidth-1:0] dataT;

	// ALU value one stage behind aluM
	dataT aluW;

	// next execute record
	stageInfoT nextE;

	// strip the decode-only control bits
	function automatic stageInfoT toStage(input decodeInfoT d);
		stageInfoT s;
		s.adr1     = d.adr1;
		s.adr2     = d.adr2;
		s.rd       = d.rd;
		s.regWrite = d.regWrite;
		s.wbSel    = d.wbSel;
		return s;
	endfunction

	// a flush turns the slot entering execute into a bubble
	always_comb begin
		if (flushE) begin
			nextE = StageBubble;
		end else begin
			nextE = toStage(decodeIn);
		end
	end

	// stage records, all bubbles out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			infoE <= StageBubble;
			infoM <= StageBubble;
			infoW <= StageBubble;
		end else begin
			infoE <= nextE;
			infoM <= infoE;
			infoW <= infoM;
		end
	end

	// data follows the records, only valid where regWrite says so
	always_ff @(posedge clk) begin
		aluM <= aluResultE;
		aluW <= aluM;
	end

	// loads take the memory word, everything else the ALU value
	always_comb begin
		if (infoW.wbSel == WbMem) begin
			resultW = memDataW;
		end else begin
			resultW = aluW;
		end
	end

endmodule

// ==== rtl/forwardSelect.sv ====
`timescale 1ns/100ps

module forwardSelect
	import hazardPkg::*;
(
	input  decodeInfoT decodeIn,
	input  stageInfoT  infoE,
	input  stageInfoT  infoM,
	input  stageInfoT  infoW,
	output fwdSelsT    fwdSels
);

	// true when the stage writes a live copy of adr
	function automatic logic hits(input regAddrT adr, input stageInfoT s);
		return (adr != RegZero) && (adr == s.rd) && s.regWrite;
	endfunction

	// memory stage is younger, so it wins over writeback
	function automatic fwdSelT pickSrc(
		input regAddrT   adr,
		input stageInfoT m,
		input stageInfoT w
	);
		fwdSelT sel;
		if (hits(adr, m)) begin
			sel = FwdAluM;
		end else if (hits(adr, w)) begin
			sel = FwdResultW;
		end else begin
			sel = FwdNone;
		end
		return sel;
	endfunction

	// decode operands feed the branch comparator
	always_comb begin
		fwdSels.fwd1D = pickSrc(decodeIn.adr1, infoM, infoW);
		fwdSels.fwd2D = pickSrc(decodeIn.adr2, infoM, infoW);
	end

	// execute operands feed the ALU
	always_comb begin
		fwdSels.fwd1E = pickSrc(infoE.adr1, infoM, infoW);
		fwdSels.fwd2E = pickSrc(infoE.adr2, infoM, infoW);
	end

endmodule

// ==== rtl/stallDetect.sv ====
`timescale 1ns/100ps

module stallDetect
	import hazardPkg::*;
(
	input  logic       rst,
	input  decodeInfoT decodeIn,
	input  stageInfoT  infoE,
	output logic       stallF,
	output logic       stallD,
	output logic       flushE
);

	// decode reads the register execute is about to produce
	logic depE;
	// value not ready until after memory
	logic loadUse;
	// comparator in decode cannot wait for the ALU
	logic ctrlUse;
	logic hazard;

	assign depE = (infoE.rd != RegZero) &&
		((infoE.rd == decodeIn.adr1) || (infoE.rd == decodeIn.adr2));

	assign loadUse = (infoE.wbSel == WbMem);

	assign ctrlUse = (decodeIn.branch || decodeIn.jump) && infoE.regWrite;

	assign hazard = !rst && depE && (loadUse || ctrlUse);

	// hold fetch and decode, send a bubble into execute
	assign stallF = hazard;
	assign stallD = hazard;
	assign flushE = hazard;

endmodule

// ==== rtl/bypassMux.sv ====
`timescale 1ns/100ps

module bypassMux
	import hazardPkg::*;
#(
	parameter int DataWidth = 32
) (
	input  fwdSelsT              fwdSels,
	input  logic                 stallD,
	input  logic [DataWidth-1:0] rf1D,
	input  logic [DataWidth-1:0] rf2D,
	input  logic [DataWidth-1:0] rf1E,
	input  logic [DataWidth-1:0] rf2E,
	input  logic [DataWidth-1:0] aluM,
	input  logic [DataWidth-1:0] resultW,
	output logic [DataWidth-1:0] op1D,
	output logic [DataWidth-1:0] op2D,
	output logic [DataWidth-1:0] op1E,
	output logic [DataWidth-1:0] op2E
);

	typedef logic [DataWidth-1:0] dataT;

	// unused code 11 falls back to the register file
	function automatic dataT pick(input fwdSelT sel, input dataT rf);
		dataT val;
		case (sel)
			FwdAluM:    val = aluM;
			FwdResultW: val = resultW;
			default:    val = rf;
		endcase
		return val;
	endfunction

	// zeroed while stalled so the comparator never sees a stale value
	always_comb begin
		if (stallD) begin
			op1D = '0;
			op2D = '0;
		end else begin
			op1D = pick(fwdSels.fwd1D, rf1D);
			op2D = pick(fwdSels.fwd2D, rf2D);
		end
	end

	always_comb begin
		op1E = pick(fwdSels.fwd1E, rf1E);
		op2E = pick(fwdSels.fwd2E, rf2E);
	end

endmodule

// ==== rtl/hazardCtrl.sv ====
`timescale 1ns/100ps

module hazardCtrl
	import hazardPkg::*;
#(
	parameter int DataWidth = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  decodeInfoT           decodeIn,
	input  logic [DataWidth-1:0] rf1D,
	input  logic [DataWidth-1:0] rf2D,
	input  logic [DataWidth-1:0] rf1E,
	input  logic [DataWidth-1:0] rf2E,
	input  logic [DataWidth-1:0] aluResultE,
	input  logic [DataWidth-1:0] memDataW,
	output logic                 stallF,
	output logic                 stallD,
	output logic                 flushE,
	output logic [DataWidth-1:0] op1D,
	output logic [DataWidth-1:0] op2D,
	output logic [DataWidth-1:0] op1E,
	output logic [DataWidth-1:0] op2E,
	output fwdSelsT              fwdSels,
	output logic [DataWidth-1:0] resultW,
	output regAddrT              rdW,
	output logic                 regWriteW
);

	// stage records shared by selector and detector
	stageInfoT infoE;
	stageInfoT infoM;
	stageInfoT infoW;

	logic [DataWidth-1:0] aluM;

	pipeTracker #(
		.DataWidth(DataWidth)
	) i_pipeTracker (
		.clk       (clk),
		.rst       (rst),
		.decodeIn  (decodeIn),
		.flushE    (flushE),
		.aluResultE(aluResultE),
		.memDataW  (memDataW),
		.infoE     (infoE),
		.infoM     (infoM),
		.infoW     (infoW),
		.aluM      (aluM),
		.resultW   (resultW)
	);

	forwardSelect i_forwardSelect (
		.decodeIn(decodeIn),
		.infoE   (infoE),
		.infoM   (infoM),
		.infoW   (infoW),
		.fwdSels (fwdSels)
	);

	stallDetect i_stallDetect (
		.rst     (rst),
		.decodeIn(decodeIn),
		.infoE   (infoE),
		.stallF  (stallF),
		.stallD  (stallD),
		.flushE  (flushE)
	);

	bypassMux #(
		.DataWidth(DataWidth)
	) i_bypassMux (
		.fwdSels(fwdSels),
		.stallD (stallD),
		.rf1D   (rf1D),
		.rf2D   (rf2D),
		.rf1E   (rf1E),
		.rf2E   (rf2E),
		.aluM   (aluM),
		.resultW(resultW),
		.op1D   (op1D),
		.op2D   (op2D),
		.op1E   (op1E),
		.op2E   (op2E)
	);

	// register file write port
	assign rdW       = infoW.rd;
	assign regWriteW = infoW.regWrite;

endmodule

// ==== test/hazardCtrl_sva.sv ====
`timescale 1ns/100ps

module hazardCtrlSva
	import hazardPkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      stallF,
	input logic      stallD,
	input logic      flushE,
	input fwdSelsT   fwdSels,
	input stageInfoT infoE,
	input stageInfoT infoM
);

	// true when any of the four selects carries code
	function automatic logic anySel(input fwdSelsT s, input fwdSelT code);
		return (s.fwd1D == code) || (s.fwd2D == code) ||
			(s.fwd1E == code) || (s.fwd2E == code);
	endfunction

	stallsAgree: assert property (@(posedge clk) disable iff (rst)
		(stallF == stallD) && (stallD == flushE))
		else $error("stallF, stallD and flushE differ");

	noReservedSel: assert property (@(posedge clk) disable iff (rst)
		!anySel(fwdSels, 2'b11))
		else $error("select code 11 seen on fwdSels");

	// memory stage can only forward what it writes
	aluMNeedsWrite: assert property (@(posedge clk) disable iff (rst)
		!infoM.regWrite |-> !anySel(fwdSels, FwdAluM))
		else $error("FwdAluM chosen while memory stage writes nothing");

	flushGivesBubble: assert property (@(posedge clk) disable iff (rst)
		flushE |=> (!infoE.regWrite && (infoE.rd == RegZero) && (infoE.wbSel == WbAlu)))
		else $error("execute stage is not a bubble after a flush");

endmodule

bind hazardCtrl hazardCtrlSva i_hazardCtrlSva (
	.clk    (clk),
	.rst    (rst),
	.stallF (stallF),
	.stallD (stallD),
	.flushE (flushE),
	.fwdSels(fwdSels),
	.infoE  (infoE),
	.infoM  (infoM)
);

// ==== test/hazardCtrlTb.sv ====
`timescale 1ns/100ps

module hazardCtrlTb
	import hazardPkg::*;
();

	localparam int DataWidth = 32;
	localparam int ResetCycles = 8;
	localparam int RandomSteps = 150;
	// directed and random tests need under 300 cycles
	localparam int MaxCycles = 400;

	typedef logic [DataWidth-1:0] dataT;

	localparam stageInfoT Bubble = '0;

	logic       clk;
	logic       rst;
	decodeInfoT decodeIn;
	dataT       rf1D;
	dataT       rf2D;
	dataT       rf1E;
	dataT       rf2E;
	dataT       aluResultE;
	dataT       memDataW;
	logic       stallF;
	logic       stallD;
	logic       flushE;
	dataT       op1D;
	dataT       op2D;
	dataT       op1E;
	dataT       op2E;
	fwdSelsT    fwdSels;
	dataT       resultW;
	regAddrT    rdW;
	logic       regWriteW;

	// shadow pipeline state after the next rising edge
	stageInfoT   mE;
	stageInfoT   mM;
	stageInfoT   mW;
	dataT        mAluM;
	dataT        mAluW;
	logic        lastHazard;
	logic [31:0] lfsr;
	int          cycles = 0;
	int          errors = 0;

	hazardCtrl #(
		.DataWidth(DataWidth)
	) i_hazardCtrl (
		.clk       (clk),
		.rst       (rst),
		.decodeIn  (decodeIn),
		.rf1D      (rf1D),
		.rf2D      (rf2D),
		.rf1E      (rf1E),
		.rf2E      (rf2E),
		.aluResultE(aluResultE),
		.memDataW  (memDataW),
		.stallF    (stallF),
		.stallD    (stallD),
		.flushE    (flushE),
		.op1D      (op1D),
		.op2D      (op2D),
		.op1E      (op1E),
		.op2E      (op2E),
		.fwdSels   (fwdSels),
		.resultW   (resultW),
		.rdW       (rdW),
		.regWriteW (regWriteW)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MaxCycles) begin
			$display("Timeout: the run went past %0d clock cycles", MaxCycles);
			$display("Errors found");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic reportFailure(input string what);
		errors++;
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkSels(input string name, input fwdSelsT exp, input fwdSelsT act);
		if (act !== exp)
			reportFailure($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic checkFlags(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp)
			reportFailure($sformatf("FAIL %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic checkData(input string name, input dataT exp, input dataT act);
		if (act !== exp)
			reportFailure($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic checkAddr(input string name, input regAddrT exp, input regAddrT act);
		if (act !== exp)
			reportFailure($sformatf("FAIL %0t %s expected %0d got %0d", $time, name, exp, act));
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
			reportFailure($sformatf("FAIL %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic decodeInfoT mkInstr(input regAddrT a1, input regAddrT a2,
		input regAddrT rd, input logic we, input wbSelT wb, input logic br, input logic jp);
		decodeInfoT d;
		d = '{adr1: a1, adr2: a2, rd: rd, regWrite: we, wbSel: wb, branch: br, jump: jp};
		return d;
	endfunction

	// a live write in M wins over W and x0 never matches
	function automatic fwdSelT expectSel(input regAddrT adr, input stageInfoT m,
		input stageInfoT w);
		if (adr == 5'd0)
			return FwdNone;
		if (m.regWrite && m.rd == adr)
			return FwdAluM;
		if (w.regWrite && w.rd == adr)
			return FwdResultW;
		return FwdNone;
	endfunction

	function automatic logic expectHazard(input logic r, input decodeInfoT d,
		input stageInfoT e);
		logic match;
		logic cause;
		match = (e.rd != 5'd0) && (e.rd == d.adr1 || e.rd == d.adr2);
		cause = (e.wbSel == WbMem) || ((d.branch || d.jump) && e.regWrite);
		return !r && match && cause;
	endfunction

	function automatic dataT selectOperand(input fwdSelT sel, input dataT rf, input dataT alu,
		input dataT res);
		if (sel == FwdAluM)
			return alu;
		if (sel == FwdResultW)
			return res;
		return rf;
	endfunction

	// drive one cycle on the falling edge, check, then advance the model
	task automatic step(input decodeInfoT d, input logic r);
		fwdSelsT     expSels;
		logic        hz;
		dataT        expRes;
		dataT        exp1D;
		dataT        exp2D;
		logic [31:0] rnd;
		@(negedge clk);
		rst = r;
		decodeIn = d;
		randBits(32, rnd);
		rf1D = rnd;
		randBits(32, rnd);
		rf2D = rnd;
		randBits(32, rnd);
		rf1E = rnd;
		randBits(32, rnd);
		rf2E = rnd;
		randBits(32, rnd);
		aluResultE = rnd;
		randBits(32, rnd);
		memDataW = rnd;
		#1;
		hz = expectHazard(r, d, mE);
		expRes = (mW.wbSel == WbMem) ? memDataW : mAluW;
		expSels.fwd1D = expectSel(d.adr1, mM, mW);
		expSels.fwd2D = expectSel(d.adr2, mM, mW);
		expSels.fwd1E = expectSel(mE.adr1, mM, mW);
		expSels.fwd2E = expectSel(mE.adr2, mM, mW);
		exp1D = hz ? '0 : selectOperand(expSels.fwd1D, rf1D, mAluM, expRes);
		exp2D = hz ? '0 : selectOperand(expSels.fwd2D, rf2D, mAluM, expRes);
		checkFlags("stallF/stallD/flushE", {3{hz}}, {stallF, stallD, flushE});
		checkSels("fwdSels", expSels, fwdSels);
		if (!r)
			checkData("resultW", expRes, resultW);
		checkData("op1D", exp1D, op1D);
		checkData("op2D", exp2D, op2D);
		checkData("op1E", selectOperand(expSels.fwd1E, rf1E, mAluM, expRes), op1E);
		checkData("op2E", selectOperand(expSels.fwd2E, rf2E, mAluM, expRes), op2E);
		checkAddr("rdW", mW.rd, rdW);
		checkBit("regWriteW", mW.regWrite, regWriteW);
		if (r) begin
			mE = Bubble;
			mM = Bubble;
			mW = Bubble;
		end else begin
			mW = mM;
			mM = mE;
			mE = hz ? Bubble : stageInfoT'{d.adr1, d.adr2, d.rd, d.regWrite, d.wbSel};
		end
		mAluW = mAluM;
		mAluM = aluResultE;
		lastHazard = hz;
	endtask

	task automatic randomInstr(output decodeInfoT d);
		logic [31:0] r;
		randBits(16, r);
		// only x0..x7 so that dependences come often
		d.adr1 = {2'b00, r[2:0]};
		d.adr2 = {2'b00, r[5:3]};
		d.rd = {2'b00, r[8:6]};
		d.regWrite = r[9];
		d.wbSel = (r[10] && r[9]) ? WbMem : WbAlu;
		d.branch = r[11] && r[12];
		d.jump = r[13] && r[14] && r[15];
	endtask

	task automatic testReset();
		decodeInfoT d;
		// rst is already high at the first rising edge
		for (int i = 0; i < ResetCycles - 1; i++) begin
			randomInstr(d);
			step(d, 1'b1);
			checkFlags("stallF/stallD/flushE", 3'b000, {stallF, stallD, flushE});
			checkSels("fwdSels", '0, fwdSels);
			checkData("op1E", rf1E, op1E);
		end
		for (int i = 0; i < 3; i++) begin
			step(mkInstr(5'd1, 5'd2, 5'd0, 1'b0, WbAlu, 1'b0, 1'b0), 1'b0);
			checkFlags("stallF/stallD/flushE", 3'b000, {stallF, stallD, flushE});
			checkSels("fwdSels", '0, fwdSels);
			checkData("op1D", rf1D, op1D);
			checkData("op2E", rf2E, op2E);
		end
	endtask

	task automatic testExecFwd();
		decodeInfoT nop;
		dataT       saved;
		nop = mkInstr(5'd0, 5'd0, 5'd0, 1'b0, WbAlu, 1'b0, 1'b0);
		// x5 written in both M and W so M wins
		step(mkInstr(5'd0, 5'd0, 5'd5, 1'b1, WbAlu, 1'b0, 1'b0), 1'b0);
		step(mkInstr(5'd0, 5'd0, 5'd5, 1'b1, WbAlu, 1'b0, 1'b0), 1'b0);
		step(mkInstr(5'd5, 5'd6, 5'd0, 1'b0, WbAlu, 1'b0, 1'b0), 1'b0);
		saved = aluResultE;
		step(nop, 1'b0);
		checkSels("fwdSels", {FwdNone, FwdNone, FwdAluM, FwdNone}, fwdSels);
		checkData("op1E", saved, op1E);
		checkData("op2E", rf2E, op2E);
		// x7 only in W while x0 written in M is never forwarded
		step(mkInstr(5'd0, 5'd0, 5'd7, 1'b1, WbAlu, 1'b0, 1'b0), 1'b0);
		step(mkInstr(5'd0, 5'd0, 5'd0, 1'b1, WbAlu, 1'b0, 1'b0), 1'b0);
		saved = aluResultE;
		step(mkInstr(5'd7, 5'd0, 5'd0, 1'b0, WbAlu, 1'b0, 1'b0), 1'b0);
		step(nop, 1'b0);
		checkSels("fwdSels", {FwdNone, FwdNone, FwdResultW, FwdNone}, fwdSels);
		checkData("op1E", saved, op1E);
		checkData("op2E", rf2E, op2E);
	endtask

	task automatic testLoadUse();
		decodeInfoT dep;
		dep = mkInstr(5'd8, 5'd2, 5'd10, 1'b1, WbAlu, 1'b0, 1'b0);
		step(mkInstr(5'd0, 5'd0, 5'd8, 1'b1, WbMem, 1'b0, 1'b0), 1'b0);
		step(dep, 1'b0);
		checkFlags("stallF/stallD/flushE", 3'b111, {stallF, stallD, flushE});
		// decode held and a bubble now in E
		step(dep, 1'b0);
		checkFlags("stallF/stallD/flushE", 3'b000, {stallF, stallD, flushE});
		step(mkInstr(5'd0, 5'd0, 5'd0, 1'b0, WbAlu, 1'b0, 1'b0), 1'b0);
		checkSels("fwdSels.fwd1E", FwdResultW, fwdSels.fwd1E);
		checkData("op1E", memDataW, op1E);
	endtask

	task automatic testBranch();
		decodeInfoT br;
		dataT       saved;
		br = mkInstr(5'd9, 5'd3, 5'd0, 1'b0, WbAlu, 1'b1, 1'b0);
		step(mkInstr(5'd0, 5'd0, 5'd9, 1'b1, WbAlu, 1'b0, 1'b0), 1'b0);
		step(br, 1'b0);
		saved = aluResultE;
		checkFlags("stallF/stallD/flushE", 3'b111, {stallF, stallD, flushE});
		checkData("op1D", '0, op1D);
		checkData("op2D", '0, op2D);
		step(br, 1'b0);
		checkFlags("stallF/stallD/flushE", 3'b000, {stallF, stallD, flushE});
		checkSels("fwdSels.fwd1D", FwdAluM, fwdSels.fwd1D);
		checkData("op1D", saved, op1D);
	endtask

	task automatic testRandom();
		decodeInfoT d;
		d = '0;
		for (int i = 0; i < RandomSteps; i++) begin
			// a stalled core keeps the same instruction in decode
			if (!lastHazard)
				randomInstr(d);
			step(d, 1'b0);
		end
	endtask

	initial begin
		rst = 1'b1;
		decodeIn = '0;
		rf1D = '0;
		rf2D = '0;
		rf1E = '0;
		rf2E = '0;
		aluResultE = '0;
		memDataW = '0;
		lfsr = 32'h311c_eaba;
		mE = Bubble;
		mM = Bubble;
		mW = Bubble;
		mAluM = '0;
		mAluW = 'x;
		lastHazard = 1'b0;
		testReset();
		testExecFwd();
		testLoadUse();
		testBranch();
		testRandom();
		if (errors == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

// ==== list.f ====
rtl/hazardPkg.sv
rtl/pipeTracker.sv
rtl/forwardSelect.sv
rtl/stallDetect.sv
rtl/bypassMux.sv
rtl/hazardCtrl.sv
test/hazardCtrl_sva.sv
test/hazardCtrlTb.sv

// ==== Bender.yml ====
package:
  name: hazard_ctrl

sources:
  # synthesizable design, package first
  - files:
      - rtl/hazardPkg.sv
      - rtl/pipeTracker.sv
      - rtl/forwardSelect.sv
      - rtl/stallDetect.sv
      - rtl/bypassMux.sv
      - rtl/hazardCtrl.sv

  # simulation only, top module hazardCtrlTb
  - target: test
    files:
      - test/hazardCtrl_sva.sv
      - test/hazardCtrlTb.sv
